// ==== verification/spi_assertions.sv ====
`default_nettype none

module spi_assertions (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire logic               host_req,
  input wire logic               host_ack,
  input wire spi_cmd_pkg::cmd_t  cmd_in,
  input wire logic               cmd_vld,
  input wire logic               cmd_rdy,
  input wire logic               read_vld,
  input wire logic               sclk,
  input wire logic               cs
);

  timeunit 1ns;
  timeprecision 100ps;

  int assert_errors = 0;

  // ack only answers a pending request
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(host_ack) |-> host_req)
    else
    begin
      $error("host_ack rose while host_req was low");
      assert_errors++;
    end

  // command held while the master is busy
  cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && !cmd_rdy) |=> $stable(cmd_in))
    else
    begin
      $error("cmd_in changed while cmd_vld was waiting");
      assert_errors++;
    end

  sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk)
    else
    begin
      $error("sclk high while cs was high");
      assert_errors++;
    end

  read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else
    begin
      $error("read_vld held for more than one cycle");
      assert_errors++;
    end

endmodule

`default_nettype wire

// ==== verification/spi_checker.sv ====
`default_nettype none

`include "spi_params.svh"

module spi_checker (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                host_req,
  input  wire logic                host_write,
  input  wire spi_cmd_pkg::addr_t  host_addr,
  input  wire spi_cmd_pkg::data_t  host_wdata,
  input  wire logic                host_ack,
  input  wire spi_cmd_pkg::data_t  host_rdata,
  input  wire logic                sclk,
  input  wire logic                cs,
  input  wire logic                mosi,
  output int                       data_errors,
  output int                       frame_errors,
  output int                       cmd_errors,
  output int                       idle_errors
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_REGS = 1 << `SPI_ADDR_WIDTH;

  spi_cmd_pkg::data_t  model_regs [0:NUM_REGS-1];
  spi_cmd_pkg::cmd_t   mosi_bits;
  int                  rise_cnt;
  logic                ack_q;
  logic                req_q;
  logic                sclk_q;
  logic                cs_q;

  always @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int n = 0; n < NUM_REGS; n++)
        model_regs[n] <= 8'hA0 + n;
      ack_q        <= 1'b0;
      req_q        <= 1'b0;
      sclk_q       <= 1'b0;
      cs_q         <= 1'b1;
      rise_cnt     <= 0;
      mosi_bits    <= '0;
      data_errors  = 0;
      frame_errors = 0;
      cmd_errors   = 0;
      idle_errors  = 0;
    end
    else
    begin
      ack_q  <= host_ack;
      req_q  <= host_req;
      sclk_q <= sclk;
      cs_q   <= cs;

      // ************************************************************************
      // register model and read data
      // ************************************************************************
      if (host_ack && !ack_q)
      begin
        if (host_write)
          model_regs[host_addr] <= host_wdata;
        else if (host_rdata !== model_regs[host_addr])
        begin
          $display("Fail read_data expected %h actual %h", model_regs[host_addr], host_rdata);
          data_errors = data_errors + 1;
        end
      end

      // ************************************************************************
      // frame length and serial command
      // ************************************************************************
      if (!cs && cs_q)
        rise_cnt <= 0;
      else if (!cs && sclk && !sclk_q)
      begin
        rise_cnt  <= rise_cnt + 1;
        mosi_bits <= {mosi_bits[`SPI_CMD_WIDTH-2:0], mosi};
      end

      if (cs && !cs_q)
      begin
        if (rise_cnt != `SPI_CMD_WIDTH)
        begin
          $display("Fail frame_length expected %0d actual %0d", `SPI_CMD_WIDTH, rise_cnt);
          frame_errors = frame_errors + 1;
        end
        if (host_write && (mosi_bits !== {1'b1, host_addr, host_wdata}))
        begin
          $display("Fail write_cmd expected %h actual %h",
                   {1'b1, host_addr, host_wdata}, mosi_bits);
          cmd_errors = cmd_errors + 1;
        end
        else if (!host_write && (mosi_bits[`SPI_CMD_WIDTH-1 -: `SPI_HDR_BITS] !==
                                 {1'b0, host_addr}))
        begin
          $display("Fail read_cmd expected %h actual %h", {1'b0, host_addr},
                   mosi_bits[`SPI_CMD_WIDTH-1 -: `SPI_HDR_BITS]);
          cmd_errors = cmd_errors + 1;
        end
      end

      // between transactions the pins and the ack rest
      if (!host_req && !req_q && ({cs, sclk, host_ack} !== 3'b100))
      begin
        $display("Fail idle_state expected 100 actual %b%b%b", cs, sclk, host_ack);
        idle_errors = idle_errors + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verification/spi_tb.sv ====
`default_nettype none

`include "spi_params.svh"

module spi_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TRANS   = 200;
  localparam int ACK_TIMEOUT = 400;
  localparam int NUM_REGS    = 1 << `SPI_ADDR_WIDTH;

  logic                clk;
  logic                rst_n;
  logic                host_req;
  logic                host_write;
  spi_cmd_pkg::addr_t  host_addr;
  spi_cmd_pkg::data_t  host_wdata;
  wire logic           host_ack;
  wire spi_cmd_pkg::data_t host_rdata;
  wire logic           sclk;
  wire logic           cs;
  wire logic           mosi;
  logic                miso;

  int                  seed;
  int                  n;
  bit                  ok;
  logic [31:0]         rnd;
  logic                write;
  logic                prev_write;
  spi_cmd_pkg::addr_t  addr;
  spi_cmd_pkg::addr_t  last_waddr;
  int                  timeout_errors;
  int                  data_errors;
  int                  frame_errors;
  int                  cmd_errors;
  int                  idle_errors;
  int                  assert_errors;

  // peripheral register file on the pins
  spi_cmd_pkg::data_t  periph_regs [0:NUM_REGS-1];
  spi_cmd_pkg::cmd_t   periph_shift = '0;
  int                  periph_cnt = 0;
  logic                periph_rd = 1'b0;
  spi_cmd_pkg::addr_t  periph_addr = '0;

  initial
    clk = 1'b0;

  always #2 clk = ~clk;

  spi_subsystem i_spi_subsystem (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_req   (host_req),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .sclk       (sclk),
    .cs         (cs),
    .mosi       (mosi),
    .miso       (miso)
  );

  spi_checker i_spi_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .host_req     (host_req),
    .host_write   (host_write),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata),
    .sclk         (sclk),
    .cs           (cs),
    .mosi         (mosi),
    .data_errors  (data_errors),
    .frame_errors (frame_errors),
    .cmd_errors   (cmd_errors),
    .idle_errors  (idle_errors)
  );

  bind spi_subsystem spi_assertions i_spi_assertions (
    .clk      (clk),
    .rst_n    (rst_n),
    .host_req (host_req),
    .host_ack (host_ack),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .read_vld (read_vld),
    .sclk     (sclk),
    .cs       (cs)
  );

  // ****************************************************************************
  // mode 0 peripheral model
  // ****************************************************************************

  always @(negedge cs)
  begin
    periph_cnt = 0;
    periph_rd  = 1'b0;
  end

  always @(posedge sclk)
  begin
    periph_shift = {periph_shift[`SPI_CMD_WIDTH-2:0], mosi};
    periph_cnt   = periph_cnt + 1;
    if (periph_cnt == `SPI_HDR_BITS)
    begin
      periph_rd   = !periph_shift[`SPI_HDR_BITS-1];
      periph_addr = periph_shift[`SPI_ADDR_WIDTH-1:0];
    end
    if ((periph_cnt == `SPI_CMD_WIDTH) && !periph_rd)
      periph_regs[periph_addr] = periph_shift[`SPI_DATA_WIDTH-1:0];
  end

  // read byte goes out MSB first once the header is in
  always @(negedge sclk)
  begin
    if (periph_rd && (periph_cnt >= `SPI_HDR_BITS) && (periph_cnt < `SPI_CMD_WIDTH))
      miso <= periph_regs[periph_addr][`SPI_CMD_WIDTH-1-periph_cnt];
  end

  // ****************************************************************************
  // host stimulus
  // ****************************************************************************

  task automatic run_transaction(input logic wr, input spi_cmd_pkg::addr_t a,
                                 input spi_cmd_pkg::data_t wd, input int idx,
                                 output bit done_ok);
    int waited;
    done_ok    = 1'b1;
    host_req   <= 1'b1;
    host_write <= wr;
    host_addr  <= a;
    host_wdata <= wd;
    waited = 0;
    while (!host_ack && (waited < ACK_TIMEOUT))
    begin
      @(posedge clk);
      waited++;
    end
    if (!host_ack)
    begin
      $display("transaction %0d got no host_ack within %0d cycles", idx, ACK_TIMEOUT);
      timeout_errors++;
      done_ok = 1'b0;
      return;
    end
    host_req <= 1'b0;
    waited = 0;
    while (host_ack && (waited < ACK_TIMEOUT))
    begin
      @(posedge clk);
      waited++;
    end
    if (host_ack)
    begin
      $display("transaction %0d kept host_ack high after host_req fell", idx);
      timeout_errors++;
      done_ok = 1'b0;
    end
  endtask

  initial
  begin
    seed           = 96;
    timeout_errors = 0;
    assert_errors  = 0;
    rst_n          = 1'b0;
    host_req       = 1'b0;
    host_write     = 1'b0;
    host_addr      = '0;
    host_wdata     = '0;
    miso           = 1'b0;
    prev_write     = 1'b0;
    last_waddr     = '0;
    for (int r = 0; r < NUM_REGS; r++)
      periph_regs[r] = 8'hA0 + r;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    n  = 0;
    ok = 1'b1;
    while ((n < NUM_TRANS) && ok)
    begin
      rnd   = $random(seed);
      write = rnd[0];
      addr  = rnd[10:8];
      // often read back the register that was just written
      if (prev_write && rnd[5])
      begin
        write = 1'b0;
        addr  = last_waddr;
      end
      if (write)
        last_waddr = addr;
      prev_write = write;
      run_transaction(write, addr, rnd[23:16], n, ok);
      n++;
    end
    repeat (4) @(posedge clk);

    assert_errors = i_spi_subsystem.i_spi_assertions.assert_errors;
    $display("errors: data %0d, frame %0d, command %0d, idle %0d, timeout %0d, assert %0d",
             data_errors, frame_errors, cmd_errors, idle_errors, timeout_errors,
             assert_errors);
    if ((data_errors + frame_errors + cmd_errors + idle_errors + timeout_errors +
         assert_errors) == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/spi_cmd_pkg.sv ====
`default_nettype none

`include "spi_params.svh"

package spi_cmd_pkg;

  // ************************************************************************
  // command word and its fields
  // ************************************************************************

  // {write flag, address, data}, sent MSB first
  typedef logic [`SPI_CMD_WIDTH-1:0] cmd_t;

  // register address inside the peripheral
  typedef logic [`SPI_ADDR_WIDTH-1:0] addr_t;

  // write data or read data byte
  typedef logic [`SPI_DATA_WIDTH-1:0] data_t;

  // counts sclk periods of one frame, must reach the full command width
  typedef logic [$clog2(`SPI_CMD_WIDTH + 1)-1:0] bit_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/spi_ctrl_pkg.sv ====
`default_nettype none

package spi_ctrl_pkg;

  // spi master sequencing
  typedef enum logic [2:0] {
    M_IDLE      = 3'd0,
    M_LOAD      = 3'd1,
    M_SHIFT_HDR = 3'd2,
    M_SHIFT_WR  = 3'd3,
    M_SHIFT_RD  = 3'd4,
    M_FINISH    = 3'd5
  } master_state_t;

  // host bridge, one host transaction per pass
  typedef enum logic [1:0] {
    B_IDLE  = 2'd0,
    B_ISSUE = 2'd1,
    B_WAIT  = 2'd2,
    B_ACK   = 2'd3
  } bridge_state_t;

endpackage

`default_nettype wire

// ==== verilog/spi_host_bridge.sv ====
`default_nettype none

`include "spi_params.svh"

module spi_host_bridge (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                host_req,
  input  wire logic                host_write,
  input  wire spi_cmd_pkg::addr_t  host_addr,
  input  wire spi_cmd_pkg::data_t  host_wdata,
  output logic                     host_ack,
  output spi_cmd_pkg::data_t       host_rdata,
  output spi_cmd_pkg::cmd_t        cmd_in,
  output logic                     cmd_vld,
  input  wire logic                cmd_rdy,
  input  wire logic                read_vld,
  input  wire spi_cmd_pkg::data_t  read_data
);

  spi_ctrl_pkg::bridge_state_t state;
  spi_ctrl_pkg::bridge_state_t state_nxt;

  spi_cmd_pkg::cmd_t   cmd_q;
  spi_cmd_pkg::data_t  wdata_field;
  logic                cmd_is_write;

  // reads carry a zero data field
  assign wdata_field  = host_write ? host_wdata : '0;
  assign cmd_is_write = cmd_q[`SPI_CMD_WIDTH-1];

  assign cmd_in   = cmd_q;
  assign cmd_vld  = (state == spi_ctrl_pkg::B_ISSUE);
  assign host_ack = (state == spi_ctrl_pkg::B_ACK);

  // ************************************************************************
  // transaction sequencing
  // ************************************************************************

  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_ctrl_pkg::B_IDLE:
      begin
        if (host_req)
          state_nxt = spi_ctrl_pkg::B_ISSUE;
      end
      spi_ctrl_pkg::B_ISSUE:
      begin
        // hold the command until the master takes it
        if (cmd_rdy)
          state_nxt = spi_ctrl_pkg::B_WAIT;
      end
      spi_ctrl_pkg::B_WAIT:
      begin
        // a write is done once the master is idle again
        if (read_vld || (cmd_is_write && cmd_rdy))
          state_nxt = spi_ctrl_pkg::B_ACK;
      end
      spi_ctrl_pkg::B_ACK:
      begin
        if (!host_req)
          state_nxt = spi_ctrl_pkg::B_IDLE;
      end
      default:
      begin
        state_nxt = spi_ctrl_pkg::B_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state <= spi_ctrl_pkg::B_IDLE;
    else
      state <= state_nxt;
  end

  // ************************************************************************
  // command and read data registers
  // ************************************************************************

  always_ff @(posedge clk)
  begin
    if ((state == spi_ctrl_pkg::B_IDLE) && host_req)
      cmd_q <= {host_write, host_addr, wdata_field};

    if ((state == spi_ctrl_pkg::B_WAIT) && read_vld)
      host_rdata <= read_data;
  end

endmodule

`default_nettype wire

// ==== verilog/spi_master.sv ====
`default_nettype none

`include "spi_params.svh"

module spi_master #(
  parameter int SCLK_DIV = 4
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire spi_cmd_pkg::cmd_t  cmd_in,
  input  wire logic               cmd_vld,
  output logic                    cmd_rdy,
  output logic                    sclk,
  output logic                    cs,
  output logic                    mosi,
  input  wire logic               miso,
  output logic                    read_vld,
  output spi_cmd_pkg::data_t      read_data
);

  localparam int DIV_W    = $clog2(SCLK_DIV);
  localparam int HALF_DIV = SCLK_DIV / 2;

  // sclk rises at the end of the low half, falls at the end of the period
  localparam logic [DIV_W-1:0] RISE_CNT = DIV_W'(HALF_DIV - 1);
  localparam logic [DIV_W-1:0] FALL_CNT = DIV_W'(SCLK_DIV - 1);

  localparam spi_cmd_pkg::bit_cnt_t HDR_LAST =
    spi_cmd_pkg::bit_cnt_t'(`SPI_HDR_BITS - 1);
  localparam spi_cmd_pkg::bit_cnt_t CMD_LAST =
    spi_cmd_pkg::bit_cnt_t'(`SPI_CMD_WIDTH - 1);

  spi_ctrl_pkg::master_state_t state;
  spi_ctrl_pkg::master_state_t state_nxt;

  logic [DIV_W-1:0]       div_cnt;
  spi_cmd_pkg::bit_cnt_t  bit_cnt;
  spi_cmd_pkg::cmd_t      buff;
  spi_cmd_pkg::data_t     rd_shift;
  logic                   is_write;
  logic                   shifting;
  logic                   rise_evt;
  logic                   fall_evt;
  logic                   last_fall;

  // ************************************************************************
  // sclk edge decode
  // ************************************************************************

  assign shifting = (state == spi_ctrl_pkg::M_SHIFT_HDR) ||
                    (state == spi_ctrl_pkg::M_SHIFT_WR)  ||
                    (state == spi_ctrl_pkg::M_SHIFT_RD);

  assign rise_evt  = shifting && (div_cnt == RISE_CNT);
  assign fall_evt  = shifting && (div_cnt == FALL_CNT);
  assign last_fall = fall_evt && (bit_cnt == CMD_LAST);

  assign cmd_rdy   = (state == spi_ctrl_pkg::M_IDLE);
  assign read_data = rd_shift;

  // ************************************************************************
  // state machine
  // ************************************************************************

  always_comb
  begin
    state_nxt = state;
    case (state)
      spi_ctrl_pkg::M_IDLE:
      begin
        if (cmd_vld)
          state_nxt = spi_ctrl_pkg::M_LOAD;
      end
      spi_ctrl_pkg::M_LOAD:
      begin
        state_nxt = spi_ctrl_pkg::M_SHIFT_HDR;
      end
      spi_ctrl_pkg::M_SHIFT_HDR:
      begin
        // flag and address are out, branch on direction
        if (fall_evt && (bit_cnt == HDR_LAST))
        begin
          if (is_write)
            state_nxt = spi_ctrl_pkg::M_SHIFT_WR;
          else
            state_nxt = spi_ctrl_pkg::M_SHIFT_RD;
        end
      end
      spi_ctrl_pkg::M_SHIFT_WR,
      spi_ctrl_pkg::M_SHIFT_RD:
      begin
        if (last_fall)
          state_nxt = spi_ctrl_pkg::M_FINISH;
      end
      spi_ctrl_pkg::M_FINISH:
      begin
        state_nxt = spi_ctrl_pkg::M_IDLE;
      end
      default:
      begin
        state_nxt = spi_ctrl_pkg::M_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= spi_ctrl_pkg::M_IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      is_write <= 1'b0;
      sclk     <= 1'b0;
      cs       <= 1'b1;
      read_vld <= 1'b0;
    end
    else
    begin
      state    <= state_nxt;
      read_vld <= (state == spi_ctrl_pkg::M_FINISH) && !is_write;

      // frame opens right after the handshake
      if (cmd_vld && cmd_rdy)
        cs <= 1'b0;
      else if (last_fall)
        cs <= 1'b1;

      if (state == spi_ctrl_pkg::M_LOAD)
      begin
        is_write <= buff[`SPI_CMD_WIDTH-1];
        div_cnt  <= '0;
        bit_cnt  <= '0;
      end
      else if (shifting)
      begin
        if (div_cnt == FALL_CNT)
          div_cnt <= '0;
        else
          div_cnt <= div_cnt + 1'b1;

        if (rise_evt)
          sclk <= 1'b1;
        if (fall_evt)
        begin
          sclk    <= 1'b0;
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // ************************************************************************
  // shift buffers
  // ************************************************************************

  // mosi moves on the falling edge, miso is taken on the rising edge
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      buff <= cmd_in;
    else if (fall_evt)
      buff <= {buff[`SPI_CMD_WIDTH-2:0], 1'b0};

    if (rise_evt && (state == spi_ctrl_pkg::M_SHIFT_RD))
      rd_shift <= {rd_shift[`SPI_DATA_WIDTH-2:0], miso};
  end

  // mosi held low outside the driven part of a frame
  always_comb
  begin
    case (state)
      spi_ctrl_pkg::M_LOAD,
      spi_ctrl_pkg::M_SHIFT_HDR,
      spi_ctrl_pkg::M_SHIFT_WR:
        mosi = buff[`SPI_CMD_WIDTH-1];
      default:
        mosi = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/spi_params.svh ====
`ifndef SPI_PARAMS_SVH
`define SPI_PARAMS_SVH

// ************************************************************************
// command word layout
// ************************************************************************

// write flag, address and data byte, in that order from the MSB
`define SPI_CMD_WIDTH   12
`define SPI_ADDR_WIDTH  3
`define SPI_DATA_WIDTH  8

// flag plus address, shifted out ahead of read data
`define SPI_HDR_BITS    4

// clk cycles per sclk period, must be even
`define SPI_SCLK_DIV    4

`endif

// ==== verilog/spi_subsystem.sv ====
`default_nettype none

`include "spi_params.svh"

module spi_subsystem (
  input  wire logic                clk,
  input  wire logic                rst_n,
  input  wire logic                host_req,
  input  wire logic                host_write,
  input  wire spi_cmd_pkg::addr_t  host_addr,
  input  wire spi_cmd_pkg::data_t  host_wdata,
  output wire logic                host_ack,
  output wire spi_cmd_pkg::data_t  host_rdata,
  output wire logic                sclk,
  output wire logic                cs,
  output wire logic                mosi,
  input  wire logic                miso
);

  // bridge to master command and read-back path
  wire spi_cmd_pkg::cmd_t   cmd_in;
  wire logic                cmd_vld;
  wire logic                cmd_rdy;
  wire logic                read_vld;
  wire spi_cmd_pkg::data_t  read_data;

  spi_host_bridge i_spi_host_bridge (
    .clk        (clk),
    .rst_n      (rst_n),
    .host_req   (host_req),
    .host_write (host_write),
    .host_addr  (host_addr),
    .host_wdata (host_wdata),
    .host_ack   (host_ack),
    .host_rdata (host_rdata),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

  spi_master #(
    .SCLK_DIV (`SPI_SCLK_DIV)
  ) i_spi_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs        (cs),
    .mosi      (mosi),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+verilog
verilog/spi_cmd_pkg.sv
verilog/spi_ctrl_pkg.sv
verilog/spi_master.sv
verilog/spi_host_bridge.sv
verilog/spi_subsystem.sv
verification/spi_assertions.sv
verification/spi_checker.sv
verification/spi_tb.sv
